// File: verilog/rv_pkg.sv
// shared widths, opcodes and ALU codes for the five-stage RV32I subset pipeline
// stages refer to these by scoped name
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // opcodes of the supported instructions
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013; // addi x0,x0,0
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // alu function, straight from funct3
    localparam logic [2:0] F3_ADD  = 3'b000; // add / sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // one instruction word seen in R, I and S format
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
    } inst_u;

endpackage

`default_nettype wire

// File: verilog/fetch_stage.sv
// fetch stage, owns the PC and the instruction read port
// IF/ID holds the fetched word and starts as a nop
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pipeline_en,
    input  logic [rv_pkg::XLEN-1:0] inst_rdata,
    output logic                    inst_read,
    output logic [rv_pkg::XLEN-1:0] inst_addr,
    output logic [rv_pkg::XLEN-1:0] id_inst
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            inst_read <= 1'b0;
            inst_addr <= rv_pkg::RESET_PC;
            id_inst   <= rv_pkg::NOP_WORD;
        end
        else
        begin
            inst_read <= 1'b1; // fetch runs continuously once out of reset
            if (pipeline_en)
            begin
                inst_addr <= inst_addr + 32'd4;
                id_inst   <= inst_rdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
// decode stage with the register file and opcode decoder
// fills the ID/EX register with the word, operands and control flags
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pipeline_en,
    input  logic [rv_pkg::XLEN-1:0]       id_inst,
    input  logic                          wb_write,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [rv_pkg::XLEN-1:0]       wb_value,
    output logic [rv_pkg::XLEN-1:0]       ex_inst,
    output logic [rv_pkg::XLEN-1:0]       ex_a,
    output logic [rv_pkg::XLEN-1:0]       ex_b,
    output logic                          ex_use_imm,
    output logic                          ex_is_lui,
    output logic                          ex_is_load,
    output logic                          ex_is_store,
    output logic                          ex_reg_write
);

    rv_pkg::inst_u          dec_word;
    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];
    logic [rv_pkg::XLEN-1:0] rs1_value;
    logic [rv_pkg::XLEN-1:0] rs2_value;
    logic                    use_imm;
    logic                    is_lui;
    logic                    is_load;
    logic                    is_store;
    logic                    reg_write;

    assign dec_word = id_inst;

    // x0 is never written, the read mux forces it to zero
    always_ff @(posedge clk)
    begin
        if (pipeline_en && wb_write && (wb_rd != '0))
            regs[wb_rd] <= wb_value;
    end

    // write-through so writeback and decode can share a cycle
    assign rs1_value = (dec_word.r.rs1 == '0) ? '0 :
                       (wb_write && (wb_rd == dec_word.r.rs1)) ? wb_value :
                       regs[dec_word.r.rs1];
    assign rs2_value = (dec_word.r.rs2 == '0) ? '0 :
                       (wb_write && (wb_rd == dec_word.r.rs2)) ? wb_value :
                       regs[dec_word.r.rs2];

    always_comb
    begin
        use_imm   = 1'b0;
        is_lui    = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        reg_write = 1'b0;
        case (dec_word.r.opcode)
            rv_pkg::OP_REG:   reg_write = 1'b1;
            rv_pkg::OP_IMM:
            begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::OP_LOAD:
            begin
                use_imm   = 1'b1;
                is_load   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::OP_STORE:
            begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            rv_pkg::OP_LUI:
            begin
                is_lui    = 1'b1;
                reg_write = 1'b1;
            end
            default: ; // unknown opcode goes on as a bubble
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_inst      <= rv_pkg::NOP_WORD;
            ex_use_imm   <= 1'b0;
            ex_is_lui    <= 1'b0;
            ex_is_load   <= 1'b0;
            ex_is_store  <= 1'b0;
            ex_reg_write <= 1'b0;
        end
        else if (pipeline_en)
        begin
            ex_inst      <= id_inst;
            ex_use_imm   <= use_imm;
            ex_is_lui    <= is_lui;
            ex_is_load   <= is_load;
            ex_is_store  <= is_store;
            ex_reg_write <= reg_write;
        end
    end

    // operand values carry no reset
    always_ff @(posedge clk)
    begin
        if (pipeline_en)
        begin
            ex_a <= rs1_value;
            ex_b <= rs2_value;
        end
    end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
// execute stage with operand forwarding, immediate select and the ALU
// results and store data go into the EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pipeline_en,
    input  logic [rv_pkg::XLEN-1:0]       ex_inst,
    input  logic [rv_pkg::XLEN-1:0]       ex_a,
    input  logic [rv_pkg::XLEN-1:0]       ex_b,
    input  logic                          ex_use_imm,
    input  logic                          ex_is_lui,
    input  logic                          ex_is_load,
    input  logic                          ex_is_store,
    input  logic                          ex_reg_write,
    input  logic [rv_pkg::XLEN-1:0]       mem_fwd_value,
    input  logic [rv_pkg::XLEN-1:0]       wb_value,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic                          wb_write,
    output logic [rv_pkg::XLEN-1:0]       mem_alu,
    output logic [rv_pkg::XLEN-1:0]       mem_store_data,
    output logic                          mem_is_load,
    output logic                          mem_is_store,
    output logic                          mem_reg_write,
    output logic [rv_pkg::REG_ADDR_W-1:0] mem_rd
);

    rv_pkg::inst_u           ex_word;
    logic [rv_pkg::XLEN-1:0] fwd_a;
    logic [rv_pkg::XLEN-1:0] fwd_b;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] opnd_b;
    logic [2:0]              alu_f3;
    logic                    alt;
    logic [4:0]              shamt;
    logic [rv_pkg::XLEN-1:0] alu_result;

    assign ex_word = ex_inst;

    // youngest producer wins, x0 never forwards
    assign fwd_a = (mem_reg_write && (mem_rd != '0) && (mem_rd == ex_word.r.rs1)) ?
                   mem_fwd_value :
                   (wb_write && (wb_rd != '0) && (wb_rd == ex_word.r.rs1)) ? wb_value : ex_a;
    assign fwd_b = (mem_reg_write && (mem_rd != '0) && (mem_rd == ex_word.r.rs2)) ?
                   mem_fwd_value :
                   (wb_write && (wb_rd != '0) && (wb_rd == ex_word.r.rs2)) ? wb_value : ex_b;

    assign imm_i  = {{20{ex_word.i.imm12[11]}}, ex_word.i.imm12};
    assign imm_s  = {{20{ex_word.s.imm_hi[6]}}, ex_word.s.imm_hi, ex_word.s.imm_lo};
    assign opnd_b = !ex_use_imm ? fwd_b : (ex_is_store ? imm_s : imm_i);

    // lw shares funct3 with slt, so memory ops force an add
    assign alu_f3 = (ex_is_load || ex_is_store) ? rv_pkg::F3_ADD : ex_word.r.funct3;
    assign alt    = ex_word.r.funct7[5]; // instruction bit 30
    assign shamt  = opnd_b[4:0];

    always_comb
    begin
        case (alu_f3)
            rv_pkg::F3_ADD:  alu_result = (alt && !ex_use_imm) ? fwd_a - opnd_b : fwd_a + opnd_b;
            rv_pkg::F3_SLL:  alu_result = fwd_a << shamt;
            rv_pkg::F3_SLT:  alu_result = {31'b0, $signed(fwd_a) < $signed(opnd_b)};
            rv_pkg::F3_SLTU: alu_result = {31'b0, fwd_a < opnd_b};
            rv_pkg::F3_XOR:  alu_result = fwd_a ^ opnd_b;
            rv_pkg::F3_SR:   alu_result = alt ? $unsigned($signed(fwd_a) >>> shamt) : fwd_a >> shamt;
            rv_pkg::F3_OR:   alu_result = fwd_a | opnd_b;
            rv_pkg::F3_AND:  alu_result = fwd_a & opnd_b;
            default:         alu_result = fwd_a + opnd_b;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_is_load   <= 1'b0;
            mem_is_store  <= 1'b0;
            mem_reg_write <= 1'b0;
        end
        else if (pipeline_en)
        begin
            mem_is_load   <= ex_is_load;
            mem_is_store  <= ex_is_store;
            mem_reg_write <= ex_reg_write;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pipeline_en)
        begin
            mem_alu        <= ex_is_lui ? {ex_inst[31:12], 12'b0} : alu_result; // lui bypasses the alu
            mem_store_data <= fwd_b;
            mem_rd         <= ex_word.r.rd;
        end
    end

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
// memory stage, drives the data port from the EX/MEM fields
// builds the forward value and the MEM/WB writeback register
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pipeline_en,
    input  logic [rv_pkg::XLEN-1:0]       mem_alu,
    input  logic [rv_pkg::XLEN-1:0]       mem_store_data,
    input  logic                          mem_is_load,
    input  logic                          mem_is_store,
    input  logic                          mem_reg_write,
    input  logic [rv_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic [rv_pkg::XLEN-1:0]       data_rdata,
    output logic                          data_read,
    output logic                          data_write,
    output logic [rv_pkg::XLEN-1:0]       data_addr,
    output logic [rv_pkg::XLEN-1:0]       data_wdata,
    output logic [rv_pkg::XLEN-1:0]       mem_fwd_value,
    output logic [rv_pkg::XLEN-1:0]       wb_value,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic                          wb_write
);

    // request comes straight from EX/MEM, so it holds while stalled
    assign data_read  = mem_is_load;
    assign data_write = mem_is_store;
    assign data_addr  = mem_alu;
    assign data_wdata = mem_store_data;

    // load data is valid whenever the stage is enabled,
    // so a dependent instruction in execute can take it this cycle
    assign mem_fwd_value = mem_is_load ? data_rdata : mem_alu;

    always_ff @(posedge clk)
    begin
        if (reset)
            wb_write <= 1'b0;
        else if (pipeline_en)
            wb_write <= mem_reg_write && (mem_rd != '0); // drop writes to x0
    end

    always_ff @(posedge clk)
    begin
        if (pipeline_en)
        begin
            wb_value <= mem_fwd_value;
            wb_rd    <= mem_rd;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pipeline_datapath.sv
// top of the five-stage pipeline with separate instruction and data ports
// one global enable stalls every stage until both memories answer
`timescale 1ns/1ps
`default_nettype none

module pipeline_datapath (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::XLEN-1:0] inst_rdata,
    input  logic                    inst_resp,
    input  logic [rv_pkg::XLEN-1:0] data_rdata,
    input  logic                    data_resp,
    output logic                    inst_read,
    output logic [rv_pkg::XLEN-1:0] inst_addr,
    output logic                    data_read,
    output logic                    data_write,
    output logic [rv_pkg::XLEN-1:0] data_addr,
    output logic [rv_pkg::XLEN-1:0] data_wdata
);

    logic                          pipeline_en;
    logic [rv_pkg::XLEN-1:0]       id_inst;
    logic [rv_pkg::XLEN-1:0]       ex_inst;
    logic [rv_pkg::XLEN-1:0]       ex_a;
    logic [rv_pkg::XLEN-1:0]       ex_b;
    logic                          ex_use_imm;
    logic                          ex_is_lui;
    logic                          ex_is_load;
    logic                          ex_is_store;
    logic                          ex_reg_write;
    logic [rv_pkg::XLEN-1:0]       mem_alu;
    logic [rv_pkg::XLEN-1:0]       mem_store_data;
    logic                          mem_is_load;
    logic                          mem_is_store;
    logic                          mem_reg_write;
    logic [rv_pkg::REG_ADDR_W-1:0] mem_rd;
    logic [rv_pkg::XLEN-1:0]       mem_fwd_value;
    logic [rv_pkg::XLEN-1:0]       wb_value;
    logic [rv_pkg::REG_ADDR_W-1:0] wb_rd;
    logic                          wb_write;

    // advance only when fetch is served and any data access is done
    assign pipeline_en = inst_resp & (data_resp | ~(data_read | data_write));

    fetch_stage fetch_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .pipeline_en (pipeline_en),
        .inst_rdata  (inst_rdata),
        .inst_read   (inst_read),
        .inst_addr   (inst_addr),
        .id_inst     (id_inst)
    );

    decode_stage decode_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .pipeline_en  (pipeline_en),
        .id_inst      (id_inst),
        .wb_write     (wb_write),
        .wb_rd        (wb_rd),
        .wb_value     (wb_value),
        .ex_inst      (ex_inst),
        .ex_a         (ex_a),
        .ex_b         (ex_b),
        .ex_use_imm   (ex_use_imm),
        .ex_is_lui    (ex_is_lui),
        .ex_is_load   (ex_is_load),
        .ex_is_store  (ex_is_store),
        .ex_reg_write (ex_reg_write)
    );

    execute_stage execute_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .pipeline_en    (pipeline_en),
        .ex_inst        (ex_inst),
        .ex_a           (ex_a),
        .ex_b           (ex_b),
        .ex_use_imm     (ex_use_imm),
        .ex_is_lui      (ex_is_lui),
        .ex_is_load     (ex_is_load),
        .ex_is_store    (ex_is_store),
        .ex_reg_write   (ex_reg_write),
        .mem_fwd_value  (mem_fwd_value),
        .wb_value       (wb_value),
        .wb_rd          (wb_rd),
        .wb_write       (wb_write),
        .mem_alu        (mem_alu),
        .mem_store_data (mem_store_data),
        .mem_is_load    (mem_is_load),
        .mem_is_store   (mem_is_store),
        .mem_reg_write  (mem_reg_write),
        .mem_rd         (mem_rd)
    );

    memory_stage memory_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .pipeline_en    (pipeline_en),
        .mem_alu        (mem_alu),
        .mem_store_data (mem_store_data),
        .mem_is_load    (mem_is_load),
        .mem_is_store   (mem_is_store),
        .mem_reg_write  (mem_reg_write),
        .mem_rd         (mem_rd),
        .data_rdata     (data_rdata),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .mem_fwd_value  (mem_fwd_value),
        .wb_value       (wb_value),
        .wb_rd          (wb_rd),
        .wb_write       (wb_write)
    );

endmodule

`default_nettype wire

// File: test/tb_pipeline.sv
// testbench for pipeline_datapath that runs the program image from the patterns file
// both memory models answer after random waits and every data write is checked in order
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int NUM_TESTS      = 5;
    localparam int MAX_STORES     = 24;

    logic        clk;
    logic        reset;
    logic [31:0] inst_rdata;
    logic        inst_resp;
    logic [31:0] data_rdata;
    logic        data_resp;
    logic        inst_read;
    logic [31:0] inst_addr;
    logic        data_read;
    logic        data_write;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;

    logic [31:0] patterns [256];
    logic [31:0] imem [128];
    logic [31:0] dmem [64];
    logic [31:0] group_size [NUM_TESTS]; // stores per test in program order
    logic [31:0] exp_addr [MAX_STORES];
    logic [31:0] exp_data [MAX_STORES];

    logic [31:0] lfsr;
    logic [1:0]  inst_wait;
    logic [1:0]  data_wait;
    logic [31:0] exp_pc;
    int          store_count;
    int          store_total;
    int          error_count;
    int          tests_passed;
    logic        timed_out;

    pipeline_datapath pipeline_datapath_inst (
        .clk        (clk),
        .reset      (reset),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .data_rdata (data_rdata),
        .data_resp  (data_resp),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_wait(output logic [1:0] delay);
        lfsr     = lfsr_step(lfsr);
        delay[0] = lfsr[0];
        lfsr     = lfsr_step(lfsr);
        delay[1] = lfsr[0];
    endtask

    function automatic string test_title(input int t);
        case (t)
            0:       return "alu register and immediate ops";
            1:       return "ex/mem and mem/wb forwarding";
            2:       return "load data used at once";
            3:       return "lui and writes to x0";
            default: return "store order under random delays";
        endcase
    endfunction

    task automatic load_patterns();
        for (int j = 0; j < 256; j++)
            patterns[j] = 32'(j) << 8; // opcode 0 passes through as a bubble
        $readmemh("test/pipeline_patterns.txt", patterns);
        for (int j = 0; j < 128; j++)
            imem[j] = patterns[j];
        for (int j = 0; j < 64; j++)
            dmem[j] = patterns[128 + j];
        store_total = 0;
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            group_size[t] = patterns[192 + t];
            store_total += int'(patterns[192 + t]);
        end
        if (store_total > MAX_STORES)
            store_total = MAX_STORES;
        for (int k = 0; k < store_total; k++)
        begin
            exp_addr[k] = patterns[208 + 2 * k];
            exp_data[k] = patterns[209 + 2 * k];
        end
    endtask

    task automatic check_reset_outputs();
        assert (inst_read == 1'b0)
        else
        begin
            $display("ERROR %0t inst_read expected 0 got %b", $time, inst_read);
            error_count++;
        end
        assert (data_read == 1'b0)
        else
        begin
            $display("ERROR %0t data_read expected 0 got %b", $time, data_read);
            error_count++;
        end
        assert (data_write == 1'b0)
        else
        begin
            $display("ERROR %0t data_write expected 0 got %b", $time, data_write);
            error_count++;
        end
    endtask

    task automatic check_fetch_addr();
        assert (inst_addr == exp_pc)
        else
        begin
            $display("ERROR %0t inst_addr expected %h got %h", $time, exp_pc, inst_addr);
            error_count++;
        end
    endtask

    task automatic check_store();
        if (store_count >= store_total)
        begin
            $display("unexpected store to %h at %0t after the last expected one", data_addr, $time);
            error_count++;
        end
        else
        begin
            assert (data_addr == exp_addr[store_count])
            else
            begin
                $display("ERROR %0t data_addr expected %h got %h",
                         $time, exp_addr[store_count], data_addr);
                error_count++;
            end
            assert (data_wdata == exp_data[store_count])
            else
            begin
                $display("ERROR %0t data_wdata expected %h got %h",
                         $time, exp_data[store_count], data_wdata);
                error_count++;
            end
        end
        dmem[data_addr[7:2]] = data_wdata;
        store_count++;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory models serve both ports at the falling edge
    initial
    begin
        inst_resp   = 1'b0;
        inst_rdata  = '0;
        data_resp   = 1'b0;
        data_rdata  = '0;
        store_count = 0;
        error_count = 0;
        exp_pc      = 32'h0000_0000;
        lfsr        = 32'hbf37_89bb;
        load_patterns();
        draw_wait(inst_wait);
        draw_wait(data_wait);
        forever
        begin
            @(negedge clk);
            inst_resp = 1'b0;
            data_resp = 1'b0;
            if (inst_read)
            begin
                if (inst_wait == 2'd0)
                begin
                    check_fetch_addr();
                    inst_resp  = 1'b1;
                    inst_rdata = imem[inst_addr[8:2]];
                end
                else
                    inst_wait = inst_wait - 2'd1;
            end
            if (data_read || data_write)
            begin
                if (data_wait == 2'd0)
                begin
                    data_resp  = 1'b1;
                    data_rdata = dmem[data_addr[7:2]];
                end
                else
                    data_wait = data_wait - 2'd1;
            end
            // pipeline advances at the next rising edge only with both sides served
            if (inst_resp && (data_resp || !(data_read || data_write)))
            begin
                exp_pc = exp_pc + 32'd4;
                draw_wait(inst_wait);
                if (data_resp)
                    draw_wait(data_wait);
                if (data_write)
                    check_store();
            end
        end
    end

    initial
    begin
        int first;
        int last;
        int cycles;
        int errors_before;
        reset        = 1'b1;
        timed_out    = 1'b0;
        tests_passed = 0;
        first        = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_reset_outputs();
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS && !timed_out; t++)
        begin
            errors_before = error_count;
            last          = first + int'(group_size[t]);
            cycles        = 0;
            while (store_count < last && cycles < TIMEOUT_CYCLES)
            begin
                @(posedge clk);
                cycles++;
            end
            if (store_count < last)
            begin
                $display("timeout in test %0d (%s), saw %0d of %0d stores",
                         t + 1, test_title(t), store_count - first, last - first);
                timed_out = 1'b1;
            end
            else if (error_count == errors_before)
            begin
                $display("test %0d %s: %0d stores, pass", t + 1, test_title(t), last - first);
                tests_passed++;
            end
            else
                $display("test %0d %s: %0d errors, fail", t + 1, test_title(t),
                         error_count - errors_before);
            first = last;
        end
        $display("stores %0d of %0d, errors %0d, tests passed %0d of %0d",
                 store_count, store_total, error_count, tests_passed, NUM_TESTS);
        if (!timed_out && error_count == 0 && store_count == store_total)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/pipeline_patterns.txt
// program image for tb_pipeline: @00 instruction words, @80 data memory words
// @c0 stores per test, @d0 expected stores as address word then data word
@00
06400093 ff900113 00300513 401101b3 // test 1: x1=100 x2=-7 x10=3, sub
40a15233 001122b3 00113333 00a093b3 // sra slt sltu sll
01c15413 0f00c493 001175b3          // srli xori and
00302023 00402223 00502423 00602623 // stores of test 1
00702823 00802a23 00902c23 00b02e23
00500613 00c606b3 00c68733 40d707b3 // test 2: dependent chain
02f02023 00176833 03002223 02e02423
12300893 02c00913 01192023          // store data from mem/wb, base from ex/mem
08002983 00198a13 03402823          // test 3: load then use
08402a83 03502a23 08802b03 01698bb3
03702c23
abcdec37 123c0c13 03802e23          // test 4: lui, then writes to x0
12345037 03700013 04002023 80000d37
05a02223
5a500d93 05b02423 04802e03 001e4eb3 // test 5: store, load back, use
05d02623 05c02823
@a0
12345678 80000001 000000f0          // data words at byte address 0x80
@c0
00000008 00000004 00000003 00000003 00000003
@d0
00000000 ffffff95 00000004 ffffffff 00000008 00000001 0000000c 00000000
00000010 00000320 00000014 0000000f 00000018 00000094 0000001c 00000060
00000020 00000005 00000024 0000006f 00000028 0000000f 0000002c 00000123
00000030 12345679 00000034 80000001 00000038 12345768
0000003c abcde123 00000040 00000000 00000044 80000000
00000048 000005a5 0000004c 000005c1 00000050 000005a5

// File: pipeline_lite.f
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/pipeline_datapath.sv
test/tb_pipeline.sv

// File: Makefile
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_pipeline
FILELIST  ?= pipeline_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
